//--- filelist.f
design/ahbSwitchPkg.sv
design/priorityArbiter.sv
design/masterPort.sv
design/slavePort.sv
design/ahbSwitch.sv
dv/ahbSwitch_asserts.sv
dv/ahbSwitchTb.sv

//--- Makefile
SRCS := $(wildcard design/*.sv dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/ahbSwitchTb: filelist.f $(SRCS)
	verilator --binary --timing --assert -f filelist.f \
		--top-module ahbSwitchTb -Mdir obj_dir -o ahbSwitchTb

run: obj_dir/ahbSwitchTb
	./obj_dir/ahbSwitchTb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/ahbSwitchTb.sv
// Testbench for the AHB3-Lite multi-layer switch
// Clock, reset, master transfer tasks, slave memory models
// with random wait states, reference functions and checks

`timescale 1ns/1ps

module ahbSwitchTb;

  localparam int       masters       = 2;
  localparam int       slaves        = 3;
  localparam int       timeoutCycles = 200;
  localparam time      clkPeriod     = 100ns;
  localparam bit [31:0] unmappedAddr = 32'h3000_0010;

  logic        HCLK;
  logic        rstN;
  logic [0:0]  mstPriority  [masters];
  logic [31:0] mstHADDR     [masters];
  logic [31:0] mstHWDATA    [masters];
  logic        mstHWRITE    [masters];
  logic [1:0]  mstHTRANS    [masters];
  logic        mstHREADY    [masters];
  logic [31:0] mstHRDATA    [masters];
  logic        mstHREADYOUT [masters];
  logic        mstHRESP     [masters];
  logic        slvHSEL      [slaves];
  logic [31:0] slvHADDR     [slaves];
  logic [31:0] slvHWDATA    [slaves];
  logic        slvHWRITE    [slaves];
  logic [1:0]  slvHTRANS    [slaves];
  logic        slvHREADYOUT [slaves];
  logic [31:0] slvHRDATA    [slaves];
  logic        slvHREADY    [slaves];
  logic        slvHRESP     [slaves];

  int          seed = 32'h1e987014;
  int          errors;
  int          checks;
  // Reference memory, last written value per address
  logic [31:0] refMem [bit [31:0]];
  // Completed reads waiting for the compare process
  string       nameQ [$];
  logic [31:0] expQ  [$];
  logic [31:0] actQ  [$];

  ahbSwitch i_ahbSwitch (.*);

  // Master HREADY is the switch's own HREADYOUT
  for (genvar m = 0; m < masters; m++)
  begin : genReady
    assign mstHREADY[m] = mstHREADYOUT[m];
  end

  initial
  begin
    HCLK = 1'b0;
    forever #(clkPeriod / 2) HCLK = ~HCLK;
  end

  //////////////////////////////
  // Slave models
  //////////////////////////////

  logic [31:0] slvMem  [slaves][256];
  logic        dphValid [slaves];
  logic        dphWrite [slaves];
  logic [31:0] dphAddr  [slaves];
  logic [31:0] lastAcc  [slaves];

  // Read data of the current data phase, word indexed
  always_comb
  begin
    for (int s = 0; s < slaves; s++)
      slvHRDATA[s] = slvMem[s][dphAddr[s][9:2]];
  end

  // Sample on the edge, commit 1 ns later
  always @(posedge HCLK)
  begin
    logic        nValid [slaves];
    logic        nWrite [slaves];
    logic [31:0] nAddr  [slaves];
    logic [31:0] wData  [slaves];
    logic        doWr   [slaves];
    logic        nReady [slaves];
    logic        expRdy;
    for (int s = 0; s < slaves; s++)
    begin
      // Slave sees its own ready while it has a data phase, high otherwise
      expRdy = dphValid[s] ? slvHREADY[s] : 1'b1;
      if (rstN)
      begin
        checks++;
        assert (slvHREADYOUT[s] === expRdy)
        else
        begin
          $display("mismatch hreadyout slave %0d: expected %b, actual %b",
                   s, expRdy, slvHREADYOUT[s]);
          errors++;
        end
      end
      nValid[s] = dphValid[s];
      nWrite[s] = dphWrite[s];
      nAddr[s]  = dphAddr[s];
      wData[s]  = slvHWDATA[s];
      doWr[s]   = 1'b0;
      nReady[s] = 1'b1;
      if (slvHREADY[s])
      begin
        doWr[s]   = dphValid[s] && dphWrite[s];
        nValid[s] = slvHSEL[s] && (slvHTRANS[s] == 2'b10);
        if (nValid[s])
        begin
          nWrite[s] = slvHWRITE[s];
          nAddr[s]  = slvHADDR[s];
        end
      end
      // About one cycle in four is a wait state
      if (nValid[s])
        nReady[s] = (($random(seed) & 3) != 0);
    end
    #1;
    for (int s = 0; s < slaves; s++)
    begin
      if (doWr[s])
        slvMem[s][dphAddr[s][9:2]] = wData[s];
      if (nValid[s] && !dphValid[s] || nAddr[s] != dphAddr[s])
        lastAcc[s] = nAddr[s];
      dphValid[s]  = nValid[s];
      dphWrite[s]  = nWrite[s];
      dphAddr[s]   = nAddr[s];
      slvHREADY[s] = nReady[s];
    end
  end

  //////////////////////////////
  // Reference functions
  //////////////////////////////

  // Slave index by base and mask, -1 when unmapped
  function automatic int expSlave(input logic [31:0] addr);
    for (int s = 0; s < slaves; s++)
      if (addr[31:28] == s[3:0])
        return s;
    return -1;
  endfunction

  function automatic logic [31:0] expRead(input logic [31:0] addr);
    if (refMem.exists(addr))
      return refMem[addr];
    return '0;
  endfunction

  //////////////////////////////
  // Master tasks
  //////////////////////////////

  task automatic waitMasterReady(input int m, input string what);
    int n;
    n = 0;
    do
    begin
      @(posedge HCLK);
      n++;
    end
    while (!mstHREADYOUT[m] && n < timeoutCycles);
    if (!mstHREADYOUT[m])
    begin
      $display("timeout: master %0d never saw HREADYOUT during %s", m, what);
      errors++;
    end
  endtask

  // One NONSEQ transfer, address phase then data phase
  task automatic transfer(input int m, input logic [31:0] addr, input logic wr,
                          input logic [31:0] data, output logic [31:0] rdata);
    @(posedge HCLK);
    #1;
    mstHADDR[m]  = addr;
    mstHWRITE[m] = wr;
    mstHTRANS[m] = 2'b10;
    waitMasterReady(m, "address phase");
    #1;
    mstHTRANS[m] = 2'b00;
    mstHWDATA[m] = data;
    waitMasterReady(m, "data phase");
    rdata = mstHRDATA[m];
    assert (mstHRESP[m] == 1'b0)
    else
    begin
      $display("error response from a mapped slave at %h", addr);
      errors++;
    end
    if (wr)
      refMem[addr] = data;
  endtask

  task automatic readCheck(input string name, input int m, input logic [31:0] addr);
    logic [31:0] rdata;
    transfer(m, addr, 1'b0, '0, rdata);
    nameQ.push_back(name);
    expQ.push_back(expRead(addr));
    actQ.push_back(rdata);
  endtask

  task automatic writeCheck(input string name, input int m, input logic [31:0] addr,
                            input logic [31:0] data);
    logic [31:0] rdata;
    transfer(m, addr, 1'b1, data, rdata);
    checks++;
    assert (lastAcc[expSlave(addr)] == addr)
    else
    begin
      $display("mismatch %s: expected %h, actual %h", name, addr, lastAcc[expSlave(addr)]);
      errors++;
    end
  endtask

  // Unmapped address, error response of exactly two cycles
  task automatic unmappedCheck(input int m);
    logic [1:0] got;
    @(posedge HCLK);
    #1;
    mstHADDR[m]  = unmappedAddr;
    mstHWRITE[m] = 1'b0;
    mstHTRANS[m] = 2'b10;
    waitMasterReady(m, "unmapped address phase");
    // No slave may see the unmapped address phase
    for (int s = 0; s < slaves; s++)
    begin
      checks++;
      assert (!slvHSEL[s])
      else
      begin
        $display("slave %0d selected by an unmapped address", s);
        errors++;
      end
    end
    #1;
    mstHTRANS[m] = 2'b00;
    for (int c = 0; c < 2; c++)
    begin
      @(posedge HCLK);
      got = {mstHREADYOUT[m], mstHRESP[m]};
      checks++;
      assert (got == {c[0], 1'b1})
      else
      begin
        $display("mismatch unmapped: expected %b, actual %b", {c[0], 1'b1}, got);
        errors++;
      end
    end
  endtask

  //////////////////////////////
  // Compare process
  //////////////////////////////

  initial
  begin
    forever
    begin
      @(posedge HCLK);
      while (actQ.size() > 0)
      begin
        string       name;
        logic [31:0] exp;
        logic [31:0] act;
        name = nameQ.pop_front();
        exp  = expQ.pop_front();
        act  = actQ.pop_front();
        checks++;
        assert (act === exp)
        else
        begin
          $display("mismatch %s: expected %h, actual %h", name, exp, act);
          errors++;
        end
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial
  begin
    logic [31:0] rd0;
    logic [31:0] rd1;
    logic [31:0] addr;
    int          n;
    int          m;
    errors = 0;
    checks = 0;
    rstN   = 1'b0;
    for (int i = 0; i < masters; i++)
    begin
      mstPriority[i] = i[0:0];
      mstHADDR[i]    = '0;
      mstHWDATA[i]   = '0;
      mstHWRITE[i]   = 1'b0;
      mstHTRANS[i]   = 2'b00;
    end
    for (int s = 0; s < slaves; s++)
    begin
      slvHREADY[s] = 1'b1;
      slvHRESP[s]  = 1'b0;
      dphValid[s]  = 1'b0;
      dphWrite[s]  = 1'b0;
      dphAddr[s]   = '0;
      lastAcc[s]   = '0;
    end
    repeat (4) @(posedge HCLK);
    #1;
    rstN = 1'b1;

    // Idle levels straight after reset
    @(posedge HCLK);
    for (int i = 0; i < masters; i++)
    begin
      checks++;
      assert (mstHREADYOUT[i] && !mstHRESP[i])
      else
      begin
        $display("master %0d not idle-ready after reset", i);
        errors++;
      end
    end

    // Every master to every slave
    for (int i = 0; i < masters; i++)
      for (int s = 0; s < slaves; s++)
      begin
        addr = {s[3:0], 20'h0, i[1:0], 6'h10};
        writeCheck("select", i, addr, 32'hA500_0000 + addr[27:0] + s);
        readCheck("readback", i, addr);
      end

    unmappedCheck(0);
    unmappedCheck(1);

    // Same slave, master 1 has the higher priority
    fork
      transfer(0, 32'h1000_0040, 1'b1, 32'h0000_C0DE, rd0);
      transfer(1, 32'h1000_0080, 1'b1, 32'h0000_BEEF, rd1);
      begin
        n = 0;
        do
        begin
          @(posedge HCLK);
          n++;
        end
        while (!slvHSEL[1] && n < timeoutCycles);
        checks++;
        assert (slvHADDR[1] == 32'h1000_0080)
        else
        begin
          $display("mismatch contest: expected %h, actual %h", 32'h1000_0080, slvHADDR[1]);
          errors++;
        end
      end
    join
    readCheck("contest0", 0, 32'h1000_0040);
    readCheck("contest1", 1, 32'h1000_0080);

    // Different slaves run in parallel
    fork
      transfer(0, 32'h0000_0100, 1'b1, 32'h1111_2222, rd0);
      transfer(1, 32'h2000_0100, 1'b1, 32'h3333_4444, rd1);
      begin
        repeat (2) @(posedge HCLK);
        checks++;
        assert (slvHSEL[0] && slvHSEL[2])
        else
        begin
          $display("parallel transfers did not select both slaves in one cycle");
          errors++;
        end
      end
    join
    readCheck("parallel0", 0, 32'h0000_0100);
    readCheck("parallel2", 1, 32'h2000_0100);

    // Random traffic under random wait states
    for (int i = 0; i < 24; i++)
    begin
      m    = {$random(seed)} % masters;
      addr = {4'({$random(seed)} % slaves), 20'h0, 6'({$random(seed)}), 2'b00};
      writeCheck("random", m, addr, $random(seed));
      readCheck("random", {$random(seed)} % masters, addr);
    end

    n = 0;
    while (actQ.size() > 0 && n < timeoutCycles)
    begin
      @(posedge HCLK);
      n++;
    end
    if (actQ.size() > 0)
    begin
      $display("compare queue did not drain");
      errors++;
    end

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- dv/ahbSwitch_asserts.sv
// Protocol assertions for the AHB3-Lite switch
// Slave select only inside the slave map, one-hot grants
// to requesting masters and the two-cycle error response

`timescale 1ns/1ps

module ahbSwitchAsserts #(
  parameter int                   addrWidth          = 32,
  parameter int                   masters            = 2,
  parameter int                   slaves             = 3,
  parameter logic [addrWidth-1:0] slaveBase [slaves] = '{default: '0},
  parameter logic [addrWidth-1:0] slaveMask [slaves] = '{default: '0}
)
(
  input logic                             HCLK,
  input logic                             rstN,
  input logic                             slvHSEL      [slaves],
  input logic [addrWidth-1:0]             slvHADDR     [slaves],
  input logic [slaves-1:0][masters-1:0]   slvSel,
  input logic [slaves-1:0][masters-1:0]   slvGrant,
  input logic                             mstHREADYOUT [masters],
  input logic                             mstHRESP     [masters]
);

  for (genvar s = 0; s < slaves; s++)
  begin : genSlv
    // Select only for an address inside this slave's window
    selMapped: assert property (@(posedge HCLK) disable iff (!rstN)
      slvHSEL[s] |-> ((slvHADDR[s] & slaveMask[s]) == (slaveBase[s] & slaveMask[s])))
      else $error("slave %0d selected outside its address window", s);

    // Any request leaves exactly one requesting master granted
    grantOneHot: assert property (@(posedge HCLK) disable iff (!rstN)
      (|slvSel[s]) |-> $onehot(slvGrant[s] & slvSel[s]))
      else $error("slave %0d grant is not one-hot on a requesting master", s);
  end

  for (genvar m = 0; m < masters; m++)
  begin : genMst
    // First error cycle with wait state, second with ready
    errPattern: assert property (@(posedge HCLK) disable iff (!rstN)
      (mstHRESP[m] && !mstHREADYOUT[m]) |=> (mstHRESP[m] && mstHREADYOUT[m]))
      else $error("master %0d error response broke the two-cycle pattern", m);
  end

endmodule

bind ahbSwitch ahbSwitchAsserts #(
  .addrWidth ( addrWidth ),
  .masters   ( masters   ),
  .slaves    ( slaves    ),
  .slaveBase ( slaveBase ),
  .slaveMask ( slaveMask )
) i_asserts (
  .HCLK         ( HCLK         ),
  .rstN         ( rstN         ),
  .slvHSEL      ( slvHSEL      ),
  .slvHADDR     ( slvHADDR     ),
  .slvSel       ( slvSel       ),
  .slvGrant     ( slvGrant     ),
  .mstHREADYOUT ( mstHREADYOUT ),
  .mstHRESP     ( mstHRESP     )
);

//--- design/ahbSwitch.sv
// Top level of the AHB3-Lite multi-layer switch
// One master port per bus master, one slave port per slave
// and the crossing of request, grant and response wires

`timescale 1ns/1ps

module ahbSwitch
  import ahbSwitchPkg::*;
#(
  parameter int                   addrWidth                = 32,
  parameter int                   dataWidth                = 32,
  parameter int                   masters                  = 2,
  parameter int                   slaves                   = 3,
  parameter logic [addrWidth-1:0] slaveBase      [slaves]  = '{32'h0000_0000,
                                                               32'h1000_0000,
                                                               32'h2000_0000},
  parameter logic [addrWidth-1:0] slaveMask      [slaves]  = '{32'hF000_0000,
                                                               32'hF000_0000,
                                                               32'hF000_0000},
  parameter bit                   errorOnNoSlave [masters] = '{default: 1'b1}
)
(
  input  logic                        HCLK,
  input  logic                        rstN,
  // Master side, AHB masters connect here
  input  logic [idxBits(masters)-1:0] mstPriority  [masters],
  input  logic [addrWidth-1:0]        mstHADDR     [masters],
  input  logic [dataWidth-1:0]        mstHWDATA    [masters],
  input  logic                        mstHWRITE    [masters],
  input  logic [1:0]                  mstHTRANS    [masters],
  input  logic                        mstHREADY    [masters],
  output logic [dataWidth-1:0]        mstHRDATA    [masters],
  output logic                        mstHREADYOUT [masters],
  output logic                        mstHRESP     [masters],
  // Slave side, AHB slaves connect here
  output logic                        slvHSEL      [slaves],
  output logic [addrWidth-1:0]        slvHADDR     [slaves],
  output logic [dataWidth-1:0]        slvHWDATA    [slaves],
  output logic                        slvHWRITE    [slaves],
  output logic [1:0]                  slvHTRANS    [slaves],
  output logic                        slvHREADYOUT [slaves],
  input  logic [dataWidth-1:0]        slvHRDATA    [slaves],
  input  logic                        slvHREADY    [slaves],
  input  logic                        slvHRESP     [slaves]
);

  // Master port outputs, shared by all slave ports
  logic [masters-1:0][slaves-1:0]     mstSel;
  logic [addrWidth-1:0]               reqAddr     [masters];
  logic [masters-1:0]                 reqWrite;
  logic [1:0]                         reqTrans    [masters];
  logic [idxBits(masters)-1:0]        reqPriority [masters];
  logic [dataWidth-1:0]               wdata       [masters];
  logic [masters-1:0]                 portReady;
  // Slave port outputs, shared by all master ports
  logic [slaves-1:0][masters-1:0]     slvGrant;
  logic [dataWidth-1:0]               slvRdata    [slaves];
  logic [slaves-1:0]                  slvReady;
  logic [slaves-1:0]                  slvResp;
  // Transposed select and grant
  logic [slaves-1:0][masters-1:0]     slvSel;
  logic [masters-1:0][slaves-1:0]     mstGrant;

  //////////////////////////////
  // Master ports
  //////////////////////////////

  for (genvar m = 0; m < masters; m++)
  begin : genMaster
    masterPort #(
      .addrWidth      ( addrWidth         ),
      .dataWidth      ( dataWidth         ),
      .masters        ( masters           ),
      .slaves         ( slaves            ),
      .slaveBase      ( slaveBase         ),
      .slaveMask      ( slaveMask         ),
      .errorOnNoSlave ( errorOnNoSlave[m] )
    ) i_masterPort (
      .HCLK           ( HCLK              ),
      .rstN           ( rstN              ),
      .mstPriority    ( mstPriority[m]    ),
      .mstHADDR       ( mstHADDR[m]       ),
      .mstHWDATA      ( mstHWDATA[m]      ),
      .mstHWRITE      ( mstHWRITE[m]      ),
      .mstHTRANS      ( mstHTRANS[m]      ),
      .mstHREADY      ( mstHREADY[m]      ),
      .mstHRDATA      ( mstHRDATA[m]      ),
      .mstHREADYOUT   ( mstHREADYOUT[m]   ),
      .mstHRESP       ( mstHRESP[m]       ),
      .reqSel         ( mstSel[m]         ),
      .reqAddr        ( reqAddr[m]        ),
      .reqWrite       ( reqWrite[m]       ),
      .reqTrans       ( reqTrans[m]       ),
      .reqPriority    ( reqPriority[m]    ),
      .wdata          ( wdata[m]          ),
      .grant          ( mstGrant[m]       ),
      .slvHRDATA      ( slvRdata          ),
      .slvHREADY      ( slvReady          ),
      .slvHRESP       ( slvResp           )
    );

    // Master HREADYOUT doubles as that master's HREADY at the slaves
    assign portReady[m] = mstHREADYOUT[m];
  end

  //////////////////////////////
  // Crossing
  //////////////////////////////

  for (genvar s = 0; s < slaves; s++)
  begin : genCrossSlv
    for (genvar m = 0; m < masters; m++)
    begin : genCrossMst
      assign slvSel[s][m]   = mstSel[m][s];
      assign mstGrant[m][s] = slvGrant[s][m];
    end
  end

  //////////////////////////////
  // Slave ports
  //////////////////////////////

  for (genvar s = 0; s < slaves; s++)
  begin : genSlave
    slavePort #(
      .addrWidth    ( addrWidth       ),
      .dataWidth    ( dataWidth       ),
      .masters      ( masters         )
    ) i_slavePort (
      .HCLK         ( HCLK            ),
      .rstN         ( rstN            ),
      .reqSel       ( slvSel[s]       ),
      .reqAddr      ( reqAddr         ),
      .reqWrite     ( reqWrite        ),
      .reqTrans     ( reqTrans        ),
      .reqPriority  ( reqPriority     ),
      .wdata        ( wdata           ),
      .mstReady     ( portReady       ),
      .grant        ( slvGrant[s]     ),
      .fwdHRDATA    ( slvRdata[s]     ),
      .fwdHREADY    ( slvReady[s]     ),
      .fwdHRESP     ( slvResp[s]      ),
      .slvHSEL      ( slvHSEL[s]      ),
      .slvHADDR     ( slvHADDR[s]     ),
      .slvHWDATA    ( slvHWDATA[s]    ),
      .slvHWRITE    ( slvHWRITE[s]    ),
      .slvHTRANS    ( slvHTRANS[s]    ),
      .slvHREADYOUT ( slvHREADYOUT[s] ),
      .slvHRDATA    ( slvHRDATA[s]    ),
      .slvHREADY    ( slvHREADY[s]    ),
      .slvHRESP     ( slvHRESP[s]     )
    );
  end

endmodule

//--- design/slavePort.sv
// Slave-side port of the AHB3-Lite switch
// Arbitration between requesting masters, address-phase mux,
// data-phase ownership and the write-data mux

`timescale 1ns/1ps

module slavePort
  import ahbSwitchPkg::*;
#(
  parameter int addrWidth = 32,
  parameter int dataWidth = 32,
  parameter int masters   = 2
)
(
  input  logic                        HCLK,
  input  logic                        rstN,
  // From the master ports
  input  logic [masters-1:0]          reqSel,
  input  logic [addrWidth-1:0]        reqAddr [masters],
  input  logic [masters-1:0]          reqWrite,
  input  logic [1:0]                  reqTrans [masters],
  input  logic [idxBits(masters)-1:0] reqPriority [masters],
  input  logic [dataWidth-1:0]        wdata [masters],
  input  logic [masters-1:0]          mstReady,
  // Back to the master ports
  output logic [masters-1:0]          grant,
  output logic [dataWidth-1:0]        fwdHRDATA,
  output logic                        fwdHREADY,
  output logic                        fwdHRESP,
  // AHB slave bus
  output logic                        slvHSEL,
  output logic [addrWidth-1:0]        slvHADDR,
  output logic [dataWidth-1:0]        slvHWDATA,
  output logic                        slvHWRITE,
  output logic [1:0]                  slvHTRANS,
  output logic                        slvHREADYOUT,
  input  logic [dataWidth-1:0]        slvHRDATA,
  input  logic                        slvHREADY,
  input  logic                        slvHRESP
);

  localparam int mstBits = idxBits(masters);

  logic [mstBits-1:0] grantIdx;
  logic               addrSel;
  logic               accept;
  logic               ownerValid;
  logic [mstBits-1:0] ownerIdx;

  //////////////////////////////
  // Arbitration
  //////////////////////////////

  priorityArbiter #(
    .masters  ( masters     )
  ) i_arbiter (
    .HCLK     ( HCLK        ),
    .rstN     ( rstN        ),
    .req      ( reqSel      ),
    .prio     ( reqPriority ),
    .accept   ( accept      ),
    .grant    ( grant       ),
    .grantIdx ( grantIdx    )
  );

  // Parked grant carries no request
  assign addrSel = reqSel[grantIdx];

  // Slave samples the address phase while its HREADY is high
  assign accept = addrSel && slvHREADY;

  //////////////////////////////
  // Address phase
  //////////////////////////////

  assign slvHSEL   = addrSel;
  assign slvHADDR  = reqAddr[grantIdx];
  assign slvHWRITE = reqWrite[grantIdx];
  // Idle whenever no master is granted
  assign slvHTRANS = addrSel ? reqTrans[grantIdx] : htIdle;

  //////////////////////////////
  // Data phase
  //////////////////////////////

  always_ff @(posedge HCLK)
  begin
    if (!rstN)
    begin
      ownerValid <= 1'b0;
      ownerIdx   <= '0;
    end
    else if (accept)
    begin
      ownerValid <= 1'b1;
      ownerIdx   <= grantIdx;
    end
    else if (slvHREADY)
      ownerValid <= 1'b0;
  end

  // Write data comes from the data-phase owner
  assign slvHWDATA = wdata[ownerIdx];

  // Owner's HREADYOUT is the HREADY seen by this slave segment
  assign slvHREADYOUT = ownerValid ? mstReady[ownerIdx] : 1'b1;

  // Responses go to every master, each one picks its owner
  assign fwdHRDATA = slvHRDATA;
  assign fwdHREADY = slvHREADY;
  assign fwdHRESP  = slvHRESP;

endmodule

//--- design/masterPort.sv
// Master-side port of the AHB3-Lite switch
// Address decoding against the slave map, hold register for
// address phases that lost arbitration, data-phase tracking,
// response muxing and the unmapped-address error response

`timescale 1ns/1ps

module masterPort
  import ahbSwitchPkg::*;
#(
  parameter int                   addrWidth           = 32,
  parameter int                   dataWidth           = 32,
  parameter int                   masters             = 2,
  parameter int                   slaves              = 3,
  parameter logic [addrWidth-1:0] slaveBase  [slaves] = '{default: '0},
  parameter logic [addrWidth-1:0] slaveMask  [slaves] = '{default: '0},
  parameter bit                   errorOnNoSlave      = 1'b1
)
(
  input  logic                        HCLK,
  input  logic                        rstN,
  // From the AHB master
  input  logic [idxBits(masters)-1:0] mstPriority,
  input  logic [addrWidth-1:0]        mstHADDR,
  input  logic [dataWidth-1:0]        mstHWDATA,
  input  logic                        mstHWRITE,
  input  logic [1:0]                  mstHTRANS,
  input  logic                        mstHREADY,
  // Back to the AHB master
  output logic [dataWidth-1:0]        mstHRDATA,
  output logic                        mstHREADYOUT,
  output logic                        mstHRESP,
  // Toward the slave ports
  output logic [slaves-1:0]           reqSel,
  output logic [addrWidth-1:0]        reqAddr,
  output logic                        reqWrite,
  output logic [1:0]                  reqTrans,
  output logic [idxBits(masters)-1:0] reqPriority,
  output logic [dataWidth-1:0]        wdata,
  // From the slave ports
  input  logic [slaves-1:0]           grant,
  input  logic [dataWidth-1:0]        slvHRDATA [slaves],
  input  logic [slaves-1:0]           slvHREADY,
  input  logic [slaves-1:0]           slvHRESP
);

  localparam int slvBits = idxBits(slaves);

  typedef enum logic [1:0] {
    errIdle,
    errFirst,
    errSecond
  } errStateT;

  //////////////////////////////
  // Address phase
  //////////////////////////////

  logic                 holdValid;
  logic [addrWidth-1:0] holdAddr;
  logic                 holdWrite;
  logic                 liveValid;
  logic                 currValid;
  logic [addrWidth-1:0] currAddr;
  logic                 hitAny;
  logic [slvBits-1:0]   selIdx;
  logic                 accepted;

  // Live request only counts while the bus is ready
  assign liveValid = mstHREADY && (mstHTRANS == htNonseq);

  // Held request takes over until a slave accepts it
  assign currValid = holdValid || liveValid;
  assign currAddr  = holdValid ? holdAddr : mstHADDR;

  // Base and mask decode, lowest slave index wins on overlap
  always_comb
  begin
    hitAny = 1'b0;
    selIdx = '0;
    for (int s = slaves - 1; s >= 0; s--)
    begin
      if ((currAddr & slaveMask[s]) == (slaveBase[s] & slaveMask[s]))
      begin
        hitAny = 1'b1;
        selIdx = s[slvBits-1:0];
      end
    end
  end

  // One-hot request toward the decoded slave
  always_comb
  begin
    reqSel = '0;
    if (currValid && hitAny)
      reqSel[selIdx] = 1'b1;
  end

  assign reqAddr     = currAddr;
  assign reqWrite    = holdValid ? holdWrite : mstHWRITE;
  assign reqTrans    = currValid ? htNonseq : htIdle;
  assign reqPriority = mstPriority;
  // Master keeps HWDATA stable while its HREADY is low
  assign wdata       = mstHWDATA;

  // Taken when granted and the slave is ready
  assign accepted = currValid && hitAny && grant[selIdx] && slvHREADY[selIdx];

  //////////////////////////////
  // State
  //////////////////////////////

  logic               dataValid;
  logic [slvBits-1:0] dataSlave;
  logic               errStart;
  errStateT           errState;

  assign errStart = errorOnNoSlave && currValid && !hitAny;

  always_ff @(posedge HCLK)
  begin
    if (!rstN)
    begin
      holdValid <= 1'b0;
      dataValid <= 1'b0;
      dataSlave <= '0;
    end
    else
    begin
      // Hold a mapped request that lost arbitration or met a busy slave
      if (holdValid)
      begin
        if (accepted)
          holdValid <= 1'b0;
      end
      else if (liveValid && hitAny && !accepted)
        holdValid <= 1'b1;

      // Data phase owner, new acceptance overlaps the closing phase
      if (accepted)
      begin
        dataValid <= 1'b1;
        dataSlave <= selIdx;
      end
      else if (dataValid && slvHREADY[dataSlave])
        dataValid <= 1'b0;
    end
  end

  // Capture every cycle outside a hold
  always_ff @(posedge HCLK)
  begin
    if (!holdValid)
    begin
      holdAddr  <= mstHADDR;
      holdWrite <= mstHWRITE;
    end
  end

  // Two-cycle error response for an unmapped address
  always_ff @(posedge HCLK)
  begin
    if (!rstN)
      errState <= errIdle;
    else if (errStart)
      errState <= errFirst;
    else if (errState == errFirst)
      errState <= errSecond;
    else
      errState <= errIdle;
  end

  //////////////////////////////
  // Response to the master
  //////////////////////////////

  always_comb
  begin
    mstHRDATA = slvHRDATA[dataSlave];
    if (errState == errFirst)
    begin
      mstHREADYOUT = 1'b0;
      mstHRESP     = hrespError;
    end
    else if (errState == errSecond)
    begin
      mstHREADYOUT = 1'b1;
      mstHRESP     = hrespError;
    end
    else if (holdValid)
    begin
      // Wait states until the held request is served
      mstHREADYOUT = 1'b0;
      mstHRESP     = hrespOkay;
    end
    else if (dataValid)
    begin
      mstHREADYOUT = slvHREADY[dataSlave];
      mstHRESP     = slvHRESP[dataSlave];
    end
    else
    begin
      mstHREADYOUT = 1'b1;
      mstHRESP     = hrespOkay;
    end
  end

endmodule

//--- design/priorityArbiter.sv
// Priority arbiter for one slave port
// Highest priority request wins, lowest index on a tie
// Parks on the last accepted owner while nobody requests

`timescale 1ns/1ps

module priorityArbiter
  import ahbSwitchPkg::*;
#(
  parameter int masters = 2
)
(
  input  logic                        HCLK,
  input  logic                        rstN,
  input  logic [masters-1:0]          req,
  input  logic [idxBits(masters)-1:0] prio [masters],
  input  logic                        accept,
  output logic [masters-1:0]          grant,
  output logic [idxBits(masters)-1:0] grantIdx
);

  localparam int mstBits = idxBits(masters);

  // Owner of the last accepted address phase
  logic [mstBits-1:0] lastOwner;

  // Running winner of the priority search
  logic [mstBits-1:0] winIdx;
  logic [mstBits-1:0] winPrio;
  logic               anyReq;

  // Priority search
  // Strict compare keeps the lowest index on equal priority
  always_comb
  begin
    anyReq  = 1'b0;
    winIdx  = lastOwner;
    winPrio = '0;
    for (int m = 0; m < masters; m++)
    begin
      if (req[m] && (!anyReq || (prio[m] > winPrio)))
      begin
        anyReq  = 1'b1;
        winIdx  = m[mstBits-1:0];
        winPrio = prio[m];
      end
    end
  end

  assign grantIdx = winIdx;

  // One-hot grant, parked on lastOwner when idle
  always_comb
  begin
    grant         = '0;
    grant[winIdx] = 1'b1;
  end

  // Winner becomes owner once the slave takes the address phase
  always_ff @(posedge HCLK)
  begin
    if (!rstN)
      lastOwner <= '0;
    else if (accept)
      lastOwner <= winIdx;
  end

endmodule

//--- design/ahbSwitchPkg.sv
// Shared definitions for the AHB3-Lite multi-layer switch
// AHB transfer-type encoding, one-bit response values
// and the index-width helper used for port and arbiter sizing

package ahbSwitchPkg;

  //////////////////////////////
  // Transfer type
  //////////////////////////////

  // HTRANS encoding as on the AHB bus
  typedef enum logic [1:0] {
    htIdle   = 2'b00,
    htBusy   = 2'b01,
    htNonseq = 2'b10,
    htSeq    = 2'b11
  } htransT;

  //////////////////////////////
  // Response
  //////////////////////////////

  // AHB3-Lite HRESP is a single bit
  localparam logic hrespOkay  = 1'b0;
  localparam logic hrespError = 1'b1;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Index width for a count of ports
  // A single port still gets one bit
  function automatic int idxBits(input int count);
    if (count <= 1)
      return 1;
    else
      return $clog2(count);
  endfunction

endpackage
